/* bench/periph_ref.svh */
`ifndef PERIPH_REF_SVH
`define PERIPH_REF_SVH

localparam logic [DATA_W-1:0] IE_MASK = DATA_W'((64'd1 << NUM_INTS) - 64'd1);

// model of the writable registers
logic              ref_core_ctrl;
logic [DATA_W-1:0] ref_scratch;
logic              ref_msip;
logic [DATA_W-1:0] ref_mtimecmp;
logic [DATA_W-1:0] ref_ie;
logic [DATA_W-1:0] ref_ints;

function automatic void model_reset();
    ref_core_ctrl = 1'b0;
    ref_scratch   = '0;
    ref_msip      = 1'b0;
    ref_mtimecmp  = '1;
    ref_ie        = '0;
    ref_ints      = '0;
endfunction

function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] cur,
    input logic [DATA_W-1:0] nv,
    input logic [STRB_W-1:0] strb
);
    logic [DATA_W-1:0] mask;
    for (int b = 0; b < DATA_W; b++) begin
        mask[b] = strb[b / 8];
    end
    return (cur & ~mask) | (nv & mask);
endfunction

// tgt 1 is intc, 0 is cfgreg
function automatic bit addr_ok(input bit tgt, input logic [11:0] ofs, input bit is_write);
    if (!tgt) begin
        return (ofs == OFS_CORE_CTRL) || (ofs == OFS_SCRATCH);
    end
    if (ofs == OFS_IP) begin
        return !is_write;
    end
    return ofs inside {OFS_MSIP, OFS_MTIME, OFS_MTIMECMP, OFS_IE};
endfunction

function automatic void model_write(
    input bit tgt,
    input logic [11:0] ofs,
    input logic [DATA_W-1:0] data,
    input logic [STRB_W-1:0] strb
);
    if (!addr_ok(tgt, ofs, 1'b1)) begin
        return;
    end
    if (!tgt && ofs == OFS_CORE_CTRL && strb[0]) begin
        ref_core_ctrl = data[0];
    end else if (!tgt && ofs == OFS_SCRATCH) begin
        ref_scratch = merge_bytes(ref_scratch, data, strb);
    end else if (tgt && ofs == OFS_MSIP && strb[0]) begin
        ref_msip = data[0];
    end else if (tgt && ofs == OFS_MTIMECMP) begin
        ref_mtimecmp = merge_bytes(ref_mtimecmp, data, strb);
    end else if (tgt && ofs == OFS_IE) begin
        ref_ie = merge_bytes(ref_ie, data, strb) & IE_MASK;
    end
endfunction

// {pslverr, prdata}, mtime data is not modeled
function automatic logic [DATA_W:0] exp_read(input bit tgt, input logic [11:0] ofs);
    logic [DATA_W-1:0] val;
    val = '0;
    if (!addr_ok(tgt, ofs, 1'b0)) begin
        return {1'b1, val};
    end
    if (!tgt) begin
        val = (ofs == OFS_CORE_CTRL) ? DATA_W'(ref_core_ctrl) : ref_scratch;
    end else begin
        case (ofs)
            OFS_MSIP:     val = DATA_W'(ref_msip);
            OFS_MTIMECMP: val = ref_mtimecmp;
            OFS_IE:       val = ref_ie;
            OFS_IP:       val = ref_ints & IE_MASK;
            default:      val = '0;
        endcase
    end
    return {1'b0, val};
endfunction

`endif

/* bench/tb_core_periph.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core_periph import periph_pkg::*; ();

localparam int NUM_INTS = 32;
localparam int NUM_ACC  = 64;
localparam logic [ADDR_W-1:0] CFG_BASE  = 32'h0000_0000;
localparam logic [ADDR_W-1:0] INTC_BASE = 32'h0800_0000;

logic clk, arst_n, psel, penable, pwrite, pslverr, pready;
logic [ADDR_W-1:0]   paddr;
logic [STRB_W-1:0]   pstrb;
logic [DATA_W-1:0]   pwdata, prdata;
logic [NUM_INTS-1:0] ints;
logic core_rstn, msip, mtip, meip;

integer seed;
logic [DATA_W:0]   exp_q[$], got_q[$];
bit                chk_q[$];
logic [ADDR_W-1:0] addr_q[$];
logic [DATA_W:0]   chk_exp, chk_got;
bit                chk_data;
logic [ADDR_W-1:0] chk_addr;
logic [DATA_W-1:0] rd_val, wdat, t0, t1;

`include "periph_ref.svh"

core_periph core_periph_inst (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .paddr(paddr),
    .pwrite(pwrite), .pstrb(pstrb), .pwdata(pwdata), .prdata(prdata),
    .pslverr(pslverr), .pready(pready), .ints(ints), .core_rstn(core_rstn),
    .msip(msip), .mtip(mtip), .meip(meip)
);

always #2 clk = ~clk;

task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "run stopped");
endtask

// one setup and one access cycle, returns 1 ns after the closing edge
task automatic apb_xfer(input bit wr, input bit tgt, input logic [11:0] ofs,
                        input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                        output logic [DATA_W-1:0] rdata);
    logic [DATA_W:0] exp;
    exp = wr ? {!addr_ok(tgt, ofs, 1'b1), DATA_W'(0)} : exp_read(tgt, ofs);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = (tgt ? INTC_BASE : CFG_BASE) | ADDR_W'(ofs);
    pstrb = wr ? strb : '0;
    pwdata = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // no wait states, the first access cycle completes
    @(negedge clk);
    assert (pready === 1'b1)
        else stop_with_error($sformatf("ERR pready got %h exp %h", pready, 1'b1));
    rdata = prdata;
    exp_q.push_back(exp);
    got_q.push_back({pslverr, prdata});
    chk_q.push_back(!wr && !(tgt && ofs == OFS_MTIME));
    addr_q.push_back(paddr);
    if (wr) begin
        model_write(tgt, ofs, data, strb);
    end
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
endtask

task automatic check_outputs();
    logic exp_meip;
    logic exp_mtip;
    @(negedge clk);
    exp_meip = |(ref_ints & ref_ie);
    // mtimecmp only ever holds 0 or all ones here
    exp_mtip = (ref_mtimecmp == '0);
    assert (core_rstn === ref_core_ctrl)
        else stop_with_error($sformatf("ERR core_rstn got %h exp %h", core_rstn, ref_core_ctrl));
    assert (msip === ref_msip)
        else stop_with_error($sformatf("ERR msip got %h exp %h", msip, ref_msip));
    assert (mtip === exp_mtip)
        else stop_with_error($sformatf("ERR mtip got %h exp %h", mtip, exp_mtip));
    assert (meip === exp_meip)
        else stop_with_error($sformatf("ERR meip got %h exp %h", meip, exp_meip));
    // bus is idle here
    assert (pready === 1'b0)
        else stop_with_error($sformatf("ERR pready got %h exp %h", pready, 1'b0));
    assert (pslverr === 1'b0)
        else stop_with_error($sformatf("ERR pslverr got %h exp %h", pslverr, 1'b0));
    @(posedge clk);
    #1;
endtask

// compares every finished transfer with the model
always @(negedge clk) begin
    while (got_q.size() > 0) begin
        chk_exp = exp_q.pop_front();
        chk_got = got_q.pop_front();
        chk_data = chk_q.pop_front();
        chk_addr = addr_q.pop_front();
        assert (chk_got[DATA_W] === chk_exp[DATA_W])
            else stop_with_error($sformatf("ERR pslverr at %h got %h exp %h",
                                           chk_addr, chk_got[DATA_W], chk_exp[DATA_W]));
        assert (!chk_data || chk_got[DATA_W-1:0] === chk_exp[DATA_W-1:0])
            else stop_with_error($sformatf("ERR prdata at %h got %h exp %h", chk_addr,
                                           chk_got[DATA_W-1:0], chk_exp[DATA_W-1:0]));
    end
end

initial begin
    #(NUM_ACC * 4 * 4 + 400);
    stop_with_error("timeout, the test sequence did not finish in time");
end

initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pstrb = '0;
    pwdata = '0;
    ints = '0;
    seed = 32'h263c4d90;
    model_reset();
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_outputs();
    // core reset release
    apb_xfer(1'b0, 1'b0, OFS_CORE_CTRL, '0, '0, rd_val);
    apb_xfer(1'b1, 1'b0, OFS_CORE_CTRL, 32'h1, 4'hf, rd_val);
    check_outputs();
    apb_xfer(1'b0, 1'b0, OFS_CORE_CTRL, '0, '0, rd_val);
    for (int i = 0; i < 12; i++) begin
        wdat = $random(seed);
        apb_xfer(1'b1, 1'b0, OFS_SCRATCH, wdat, STRB_W'($random(seed)), rd_val);
        apb_xfer(1'b0, 1'b0, OFS_SCRATCH, '0, '0, rd_val);
    end
    // holes in both targets, ip is read only
    apb_xfer(1'b0, 1'b0, 12'h008, '0, '0, rd_val);
    apb_xfer(1'b1, 1'b0, 12'h008, 32'hdead_beef, 4'hf, rd_val);
    apb_xfer(1'b0, 1'b0, 12'hffc, '0, '0, rd_val);
    apb_xfer(1'b0, 1'b1, 12'h014, '0, '0, rd_val);
    apb_xfer(1'b1, 1'b1, 12'h100, 32'hffff_ffff, 4'hf, rd_val);
    apb_xfer(1'b1, 1'b1, OFS_IP, 32'hffff_ffff, 4'hf, rd_val);
    apb_xfer(1'b0, 1'b0, OFS_SCRATCH, '0, '0, rd_val);
    apb_xfer(1'b0, 1'b1, OFS_IE, '0, '0, rd_val);
    apb_xfer(1'b0, 1'b1, OFS_MSIP, '0, '0, rd_val);
    apb_xfer(1'b0, 1'b1, OFS_MTIMECMP, '0, '0, rd_val);
    // software interrupt
    apb_xfer(1'b1, 1'b1, OFS_MSIP, 32'h1, 4'hf, rd_val);
    check_outputs();
    apb_xfer(1'b0, 1'b1, OFS_MSIP, '0, '0, rd_val);
    apb_xfer(1'b1, 1'b1, OFS_MSIP, 32'h0, 4'hf, rd_val);
    check_outputs();
    apb_xfer(1'b0, 1'b1, OFS_MSIP, '0, '0, rd_val);
    // timer
    apb_xfer(1'b1, 1'b1, OFS_MTIMECMP, 32'hffff_ffff, 4'hf, rd_val);
    check_outputs();
    apb_xfer(1'b1, 1'b1, OFS_MTIMECMP, 32'h0, 4'hf, rd_val);
    check_outputs();
    apb_xfer(1'b0, 1'b1, OFS_MTIME, '0, '0, t0);
    apb_xfer(1'b0, 1'b1, OFS_MTIME, '0, '0, t1);
    assert (t1 >= t0)
        else stop_with_error($sformatf("ERR prdata mtime fell from %h to %h", t0, t1));
    // external interrupts
    for (int i = 0; i < 8; i++) begin
        ints = NUM_INTS'($random(seed));
        ref_ints = DATA_W'(ints);
        wdat = $random(seed);
        apb_xfer(1'b1, 1'b1, OFS_IE, wdat, STRB_W'($random(seed)), rd_val);
        apb_xfer(1'b0, 1'b1, OFS_IP, '0, '0, rd_val);
        check_outputs();
    end
    repeat (2) @(posedge clk);
    if (got_q.size() == 0) begin
        $display("all tests passed");
        $finish;
    end else begin
        stop_with_error("transfers were left unchecked at the end of the run");
    end
end

endmodule

`default_nettype wire

/* rtl/apb_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_decode import periph_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                psel,
    input  logic                penable,
    input  logic [ADDR_W-1:0]   paddr,
    input  logic                pwrite,
    input  logic [STRB_W-1:0]   pstrb,
    input  logic [DATA_W-1:0]   pwdata,
    input  logic [DATA_W-1:0]   cfg_rdata,
    input  logic [DATA_W-1:0]   intc_rdata,
    output logic [DATA_W-1:0]   prdata,
    output logic                pslverr,
    output logic                pready,

    output reg_e                reg_sel,
    output logic                wr_en,
    output logic                rd_en,
    output logic [DATA_W-1:0]   wdata,
    output logic [STRB_W-1:0]   wstrb
);

apb_state_e  state;
apb_state_e  state_nxt;
reg_e        dec_reg;
logic        access_cyc;
logic        dec_err;

// state holds the bus phase seen in the previous cycle
always_comb begin
    if (psel && !penable) begin
        state_nxt = ST_SETUP;
    end else if (psel && penable) begin
        state_nxt = ST_ACCESS;
    end else begin
        state_nxt = ST_IDLE;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= ST_IDLE;
    end else begin
        state <= state_nxt;
    end
end

// first access cycle only, no wait states
assign access_cyc = (state == ST_SETUP) && psel && penable;

always_comb begin
    dec_reg = REG_NONE;
    if (paddr[TGT_BIT]) begin
        case (paddr[11:0])
            OFS_MSIP:     dec_reg = REG_MSIP;
            OFS_MTIME:    dec_reg = REG_MTIME;
            OFS_MTIMECMP: dec_reg = REG_MTIMECMP;
            OFS_IE:       dec_reg = REG_IE;
            // ip is read only
            OFS_IP:       dec_reg = pwrite ? REG_NONE : REG_IP;
            default:      dec_reg = REG_NONE;
        endcase
    end else begin
        case (paddr[11:0])
            OFS_CORE_CTRL: dec_reg = REG_CORE_CTRL;
            OFS_SCRATCH:   dec_reg = REG_SCRATCH;
            default:       dec_reg = REG_NONE;
        endcase
    end
end

assign dec_err = (dec_reg == REG_NONE);

assign reg_sel = access_cyc ? dec_reg : REG_NONE;
assign wr_en   = access_cyc && pwrite && !dec_err;
assign rd_en   = access_cyc && !pwrite && !dec_err;
assign wdata   = access_cyc ? pwdata : '0;
assign wstrb   = access_cyc ? pstrb : '0;

// response
assign pready  = access_cyc;
assign pslverr = access_cyc && dec_err;

always_comb begin
    if (!access_cyc || dec_err) begin
        prdata = '0;
    end else if (paddr[TGT_BIT]) begin
        prdata = intc_rdata;
    end else begin
        prdata = cfg_rdata;
    end
end

assert property (@(posedge clk) disable iff (!arst_n) $rose(penable) |-> $past(psel))
    else $error("penable rose without psel in the previous cycle");

assert property (@(posedge clk) disable iff (!arst_n) !(wr_en && rd_en))
    else $error("wr_en and rd_en both high");

endmodule

`default_nettype wire

/* rtl/cfgreg.sv */
`timescale 1ns/1ns
`default_nettype none

module cfgreg import periph_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,

    input  reg_e                reg_sel,
    input  logic                wr_en,
    input  logic                rd_en,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [STRB_W-1:0]   wstrb,
    output logic [DATA_W-1:0]   cfg_rdata,

    output logic                core_rstn
);

logic [DATA_W-1:0] scratch;
logic              wr_ctrl;
logic              wr_scratch;

assign wr_ctrl    = wr_en && (reg_sel == REG_CORE_CTRL);
assign wr_scratch = wr_en && (reg_sel == REG_SCRATCH);

// core_ctrl bit 0 releases the core reset
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        core_rstn <= 1'b0;
    end else if (wr_ctrl && wstrb[0]) begin
        core_rstn <= wdata[0];
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        scratch <= '0;
    end else if (wr_scratch) begin
        scratch <= strb_merge(scratch, wdata, wstrb);
    end
end

always_comb begin
    cfg_rdata = '0;
    if (rd_en) begin
        case (reg_sel)
            REG_CORE_CTRL: cfg_rdata = {{(DATA_W-1){1'b0}}, core_rstn};
            REG_SCRATCH:   cfg_rdata = scratch;
            default:       cfg_rdata = '0;
        endcase
    end
end

assert property (@(posedge clk) !arst_n |-> !core_rstn)
    else $error("core_rstn high during reset");

endmodule

`default_nettype wire

/* rtl/core_periph.sv */
`timescale 1ns/1ns
`default_nettype none

module core_periph import periph_pkg::*; #(
    parameter int NUM_INTS = 32
) (
    input  logic                clk,
    input  logic                arst_n,

    // apb slave
    input  logic                psel,
    input  logic                penable,
    input  logic [ADDR_W-1:0]   paddr,
    input  logic                pwrite,
    input  logic [STRB_W-1:0]   pstrb,
    input  logic [DATA_W-1:0]   pwdata,
    output logic [DATA_W-1:0]   prdata,
    output logic                pslverr,
    output logic                pready,

    input  logic [NUM_INTS-1:0] ints,
    output logic                core_rstn,
    output logic                msip,
    output logic                mtip,
    output logic                meip
);

reg_e              reg_sel;
logic              wr_en;
logic              rd_en;
logic [DATA_W-1:0] wdata;
logic [STRB_W-1:0] wstrb;
logic [DATA_W-1:0] cfg_rdata;
logic [DATA_W-1:0] intc_rdata;

apb_decode u_apb_decode (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .psel       ( psel       ),
    .penable    ( penable    ),
    .paddr      ( paddr      ),
    .pwrite     ( pwrite     ),
    .pstrb      ( pstrb      ),
    .pwdata     ( pwdata     ),
    .cfg_rdata  ( cfg_rdata  ),
    .intc_rdata ( intc_rdata ),
    .prdata     ( prdata     ),
    .pslverr    ( pslverr    ),
    .pready     ( pready     ),
    .reg_sel    ( reg_sel    ),
    .wr_en      ( wr_en      ),
    .rd_en      ( rd_en      ),
    .wdata      ( wdata      ),
    .wstrb      ( wstrb      )
);

cfgreg u_cfgreg (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .reg_sel    ( reg_sel    ),
    .wr_en      ( wr_en      ),
    .rd_en      ( rd_en      ),
    .wdata      ( wdata      ),
    .wstrb      ( wstrb      ),
    .cfg_rdata  ( cfg_rdata  ),
    .core_rstn  ( core_rstn  )
);

intc #(
    .NUM_INTS   ( NUM_INTS   )
) u_intc (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .core_rstn  ( core_rstn  ),
    .reg_sel    ( reg_sel    ),
    .wr_en      ( wr_en      ),
    .rd_en      ( rd_en      ),
    .wdata      ( wdata      ),
    .wstrb      ( wstrb      ),
    .intc_rdata ( intc_rdata ),
    .ints       ( ints       ),
    .msip       ( msip       ),
    .mtip       ( mtip       ),
    .meip       ( meip       )
);

endmodule

`default_nettype wire

/* rtl/intc.sv */
`timescale 1ns/1ns
`default_nettype none

module intc import periph_pkg::*; #(
    parameter int NUM_INTS = 32
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                core_rstn,

    input  reg_e                reg_sel,
    input  logic                wr_en,
    input  logic                rd_en,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [STRB_W-1:0]   wstrb,
    output logic [DATA_W-1:0]   intc_rdata,

    input  logic [NUM_INTS-1:0] ints,
    output logic                msip,
    output logic                mtip,
    output logic                meip
);

logic [DATA_W-1:0]   mtime;
logic [DATA_W-1:0]   mtimecmp;
logic [NUM_INTS-1:0] ie;
logic [NUM_INTS-1:0] ip;
logic [DATA_W-1:0]   ie_wr;

logic wr_msip;
logic wr_mtime;
logic wr_mtimecmp;
logic wr_ie;

assign wr_msip     = wr_en && (reg_sel == REG_MSIP);
assign wr_mtime    = wr_en && (reg_sel == REG_MTIME);
assign wr_mtimecmp = wr_en && (reg_sel == REG_MTIMECMP);
assign wr_ie       = wr_en && (reg_sel == REG_IE);

// software interrupt
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        msip <= 1'b0;
    end else if (wr_msip && wstrb[0]) begin
        msip <= wdata[0];
    end
end

// timer held at zero until the core is released
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtime <= '0;
    end else if (!core_rstn) begin
        mtime <= '0;
    end else if (wr_mtime) begin
        mtime <= strb_merge(mtime, wdata, wstrb);
    end else begin
        mtime <= mtime + 1'b1;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtimecmp <= '1;
    end else if (wr_mtimecmp) begin
        mtimecmp <= strb_merge(mtimecmp, wdata, wstrb);
    end
end

assign mtip = (mtime >= mtimecmp);

// only the low NUM_INTS enable bits exist
assign ie_wr = strb_merge(DATA_W'(ie), wdata, wstrb);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ie <= '0;
        ip <= '0;
    end else begin
        ip <= ints;
        if (wr_ie) begin
            ie <= ie_wr[NUM_INTS-1:0];
        end
    end
end

assign meip = |(ip & ie);

always_comb begin
    intc_rdata = '0;
    if (rd_en) begin
        case (reg_sel)
            REG_MSIP:     intc_rdata = {{(DATA_W-1){1'b0}}, msip};
            REG_MTIME:    intc_rdata = mtime;
            REG_MTIMECMP: intc_rdata = mtimecmp;
            REG_IE:       intc_rdata = DATA_W'(ie);
            REG_IP:       intc_rdata = DATA_W'(ip);
            default:      intc_rdata = '0;
        endcase
    end
end

assert property (@(posedge clk) disable iff (!arst_n) (ie == '0) |-> !meip)
    else $error("meip high with all enables clear");

endmodule

`default_nettype wire

/* rtl/periph_pkg.sv */
`default_nettype none

package periph_pkg;

localparam int DATA_W  = 32;
localparam int STRB_W  = DATA_W / 8;
localparam int ADDR_W  = 32;
localparam int TGT_BIT = 27;

// cfgreg offsets
localparam logic [11:0] OFS_CORE_CTRL = 12'h000;
localparam logic [11:0] OFS_SCRATCH   = 12'h004;

// intc offsets
localparam logic [11:0] OFS_MSIP      = 12'h000;
localparam logic [11:0] OFS_MTIME     = 12'h004;
localparam logic [11:0] OFS_MTIMECMP  = 12'h008;
localparam logic [11:0] OFS_IE        = 12'h00c;
localparam logic [11:0] OFS_IP        = 12'h010;

typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
} apb_state_e;

typedef enum logic [2:0] {
    REG_NONE,
    REG_CORE_CTRL,
    REG_SCRATCH,
    REG_MSIP,
    REG_MTIME,
    REG_MTIMECMP,
    REG_IE,
    REG_IP
} reg_e;

// replace the bytes selected by strb
function automatic logic [DATA_W-1:0] strb_merge(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [STRB_W-1:0] strb
);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) begin
            res[i*8 +: 8] = new_val[i*8 +: 8];
        end
    end
    return res;
endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_core_periph -o sim_tb
./obj_dir/sim_tb

/* tb.f */
+incdir+bench
rtl/periph_pkg.sv
rtl/apb_decode.sv
rtl/cfgreg.sv
rtl/intc.sv
rtl/core_periph.sv
bench/tb_core_periph.sv
